// ==== logic/uart_echo_pkg.sv ====
// uart echo shared definitions
// byte and count types, line terminators and bit timing helpers
package uart_echo_pkg;

    // one data byte on the serial line
    typedef logic [7:0] uart_byte_t;

    // byte count, wide enough for the buffer plus the two terminators
    typedef logic [7:0] len_t;

    // terminator appended to every echoed string
    localparam uart_byte_t CHAR_CR = 8'h0D;
    localparam uart_byte_t CHAR_LF = 8'h0A;

    // idle line time that closes a string, two full 8N1 frames
    localparam int IDLE_BITS = 20;

    // clock cycles per serial bit, rounded to the nearest whole cycle
    function automatic int clks_per_bit(input int clk_freq, input int baud_rate);
        return (clk_freq + baud_rate / 2) / baud_rate;
    endfunction

endpackage

// ==== logic/uart_rx.sv ====
// uart receiver, 8N1
// samples each bit at its centre and strobes a byte when the stop bit is high
`timescale 1ns/1ps

module uart_rx #(
    parameter int CLK_FREQ  = 50_000_000,
    parameter int BAUD_RATE = 115_200
) (
    input  logic                      sys_clk,
    input  logic                      sys_rst_n,
    input  logic                      rxd,
    output uart_echo_pkg::uart_byte_t rx_byte,
    output logic                      rx_valid
);
    import uart_echo_pkg::*;

    localparam int CPB   = clks_per_bit(CLK_FREQ, BAUD_RATE);
    localparam int CNT_W = $clog2(CPB + 1);
    localparam logic [CNT_W-1:0] BIT_LAST  = CNT_W'(CPB - 1);
    localparam logic [CNT_W-1:0] HALF_LAST = CNT_W'(CPB / 2 - 1);

    // receiver states
    localparam logic [1:0] RX_IDLE  = 2'd0;
    localparam logic [1:0] RX_START = 2'd1;
    localparam logic [1:0] RX_DATA  = 2'd2;
    localparam logic [1:0] RX_STOP  = 2'd3;

    logic [1:0]       state;
    logic [CNT_W-1:0] cnt;
    logic [2:0]       bit_idx;
    // two-flop synchronizer plus one stage for edge detect
    logic             rx_s1;
    logic             rx_s2;
    logic             rx_s3;
    logic             rx_fall;
    uart_byte_t       shift;

    // line idles high, so the flops reset high too
    always_ff @(posedge sys_clk) begin
        if (!sys_rst_n) begin
            rx_s1 <= 1'b1;
            rx_s2 <= 1'b1;
            rx_s3 <= 1'b1;
        end else begin
            rx_s1 <= rxd;
            rx_s2 <= rx_s1;
            rx_s3 <= rx_s2;
        end
    end

    assign rx_fall = rx_s3 && !rx_s2;

    always_ff @(posedge sys_clk) begin
        if (!sys_rst_n) begin
            state    <= RX_IDLE;
            cnt      <= '0;
            bit_idx  <= '0;
            rx_valid <= 1'b0;
        end else begin
            rx_valid <= 1'b0;
            case (state)
                RX_IDLE: begin
                    cnt <= '0;
                    if (rx_fall) begin
                        state <= RX_START;
                    end
                end
                RX_START: begin
                    // half a bit in, the line must still be low
                    if (cnt == HALF_LAST) begin
                        cnt     <= '0;
                        bit_idx <= '0;
                        state   <= rx_s2 ? RX_IDLE : RX_DATA;
                    end else begin
                        cnt <= cnt + 1'b1;
                    end
                end
                RX_DATA: begin
                    if (cnt == BIT_LAST) begin
                        cnt     <= '0;
                        bit_idx <= bit_idx + 1'b1;
                        if (bit_idx == 3'd7) begin
                            state <= RX_STOP;
                        end
                    end else begin
                        cnt <= cnt + 1'b1;
                    end
                end
                default: begin
                    // low stop bit means framing error, byte is dropped
                    if (cnt == BIT_LAST) begin
                        cnt      <= '0;
                        rx_valid <= rx_s2;
                        state    <= RX_IDLE;
                    end else begin
                        cnt <= cnt + 1'b1;
                    end
                end
            endcase
        end
    end

    // data comes lsb first, shift in from the top
    always_ff @(posedge sys_clk) begin
        if (state == RX_DATA && cnt == BIT_LAST) begin
            shift <= {rx_s2, shift[7:1]};
        end
    end

    assign rx_byte = shift;

endmodule

// ==== logic/uart_tx.sv ====
// uart transmitter, 8N1
// sends one frame per start strobe, busy until the stop bit is done
`timescale 1ns/1ps

module uart_tx #(
    parameter int CLK_FREQ  = 50_000_000,
    parameter int BAUD_RATE = 115_200
) (
    input  logic                      sys_clk,
    input  logic                      sys_rst_n,
    input  logic                      tx_start,
    input  uart_echo_pkg::uart_byte_t tx_byte,
    output logic                      txd,
    output logic                      tx_busy
);
    import uart_echo_pkg::*;

    localparam int CPB   = clks_per_bit(CLK_FREQ, BAUD_RATE);
    localparam int CNT_W = $clog2(CPB + 1);
    localparam logic [CNT_W-1:0] BIT_LAST = CNT_W'(CPB - 1);

    logic [CNT_W-1:0] cnt;
    logic [3:0]       bit_idx;
    // frame[0] is the bit currently on the line
    logic [9:0]       frame;

    always_ff @(posedge sys_clk) begin
        if (!sys_rst_n) begin
            tx_busy <= 1'b0;
            txd     <= 1'b1;
            cnt     <= '0;
            bit_idx <= '0;
        end else if (!tx_busy) begin
            cnt     <= '0;
            bit_idx <= '0;
            // start bit goes out right away
            if (tx_start) begin
                tx_busy <= 1'b1;
                txd     <= 1'b0;
            end
        end else if (cnt == BIT_LAST) begin
            cnt <= '0;
            if (bit_idx == 4'd9) begin
                // stop bit complete, line stays high
                tx_busy <= 1'b0;
            end else begin
                bit_idx <= bit_idx + 1'b1;
                txd     <= frame[1];
            end
        end else begin
            cnt <= cnt + 1'b1;
        end
    end

    // stop, data, start, sent from bit 0 upward
    always_ff @(posedge sys_clk) begin
        if (!tx_busy && tx_start) begin
            frame <= {1'b1, tx_byte, 1'b0};
        end else if (tx_busy && cnt == BIT_LAST) begin
            frame <= {1'b1, frame[9:1]};
        end
    end

endmodule

// ==== logic/uart_string_handle.sv ====
// uart string handler
// gathers received bytes into a string, closes it on idle gap or full buffer,
// and sends a requested string back out followed by cr lf
`timescale 1ns/1ps

module uart_string_handle #(
    parameter int CLK_FREQ  = 50_000_000,
    parameter int BAUD_RATE = 115_200,
    parameter int MAX_LEN   = 32
) (
    input  logic                                    sys_clk,
    input  logic                                    sys_rst_n,

    input  uart_echo_pkg::uart_byte_t [MAX_LEN-1:0] tx_string,
    input  uart_echo_pkg::len_t                     tx_length,
    input  logic                                    tx_req,
    output logic                                    tx_busy,
    output logic                                    tx_done,

    output uart_echo_pkg::uart_byte_t [MAX_LEN-1:0] rx_string,
    output uart_echo_pkg::len_t                     rx_length,
    output logic                                    rx_busy,
    output logic                                    rx_done,
    output uart_echo_pkg::uart_byte_t               rx_byte,
    output logic                                    rx_byte_valid,

    input  logic                                    uart_rx_port,
    output logic                                    uart_tx_port
);
    import uart_echo_pkg::*;

    localparam int IDX_W     = $clog2(MAX_LEN);
    localparam int IDLE_CLKS = IDLE_BITS * clks_per_bit(CLK_FREQ, BAUD_RATE);
    localparam int IDLE_W    = $clog2(IDLE_CLKS + 1);
    localparam logic [IDLE_W-1:0] IDLE_LAST = IDLE_W'(IDLE_CLKS - 1);
    localparam len_t              LEN_LAST  = len_t'(MAX_LEN - 1);

    // receive side
    logic              rx_accept;
    len_t              rx_count;
    logic [IDLE_W-1:0] idle_cnt;

    // transmit side
    logic                          tx_line_busy;
    logic                          tx_start;
    uart_byte_t                    tx_char;
    uart_byte_t [MAX_LEN-1:0]      tx_buf;
    len_t                          tx_len;
    len_t                          tx_idx;
    len_t                          tx_end;

    uart_rx #(
        .CLK_FREQ  (CLK_FREQ),
        .BAUD_RATE (BAUD_RATE)
    ) u_uart_rx (
        .sys_clk   (sys_clk),
        .sys_rst_n (sys_rst_n),
        .rxd       (uart_rx_port),
        .rx_byte   (rx_byte),
        .rx_valid  (rx_byte_valid)
    );

    // nothing is stored while an echo is running
    assign rx_accept = rx_byte_valid && !tx_busy;

    always_ff @(posedge sys_clk) begin
        if (!sys_rst_n) begin
            rx_count  <= '0;
            rx_length <= '0;
            rx_busy   <= 1'b0;
            rx_done   <= 1'b0;
            idle_cnt  <= '0;
        end else begin
            rx_done <= 1'b0;
            if (rx_accept) begin
                idle_cnt <= '0;
                if (rx_count == LEN_LAST) begin
                    // buffer full, close the string now
                    rx_done   <= 1'b1;
                    rx_length <= rx_count + 1'b1;
                    rx_count  <= '0;
                    rx_busy   <= 1'b0;
                end else begin
                    rx_count <= rx_count + 1'b1;
                    rx_busy  <= 1'b1;
                end
            end else if (rx_busy) begin
                // idle gap timer, restarted by every byte
                if (idle_cnt == IDLE_LAST) begin
                    idle_cnt  <= '0;
                    rx_done   <= 1'b1;
                    rx_length <= rx_count;
                    rx_count  <= '0;
                    rx_busy   <= 1'b0;
                end else begin
                    idle_cnt <= idle_cnt + 1'b1;
                end
            end
        end
    end

    // byte 0 lands in the lowest bits
    always_ff @(posedge sys_clk) begin
        if (rx_accept) begin
            rx_string[rx_count[IDX_W-1:0]] <= rx_byte;
        end
    end

    // string bytes, then cr, then lf
    assign tx_end = tx_len + len_t'(2);

    always_comb begin
        if (tx_idx < tx_len) begin
            tx_char = tx_buf[tx_idx[IDX_W-1:0]];
        end else if (tx_idx == tx_len) begin
            tx_char = CHAR_CR;
        end else begin
            tx_char = CHAR_LF;
        end
    end

    // fires in the first cycle the line is free, so frames are back to back
    assign tx_start = tx_busy && !tx_line_busy && (tx_idx != tx_end);

    always_ff @(posedge sys_clk) begin
        if (!sys_rst_n) begin
            tx_busy <= 1'b0;
            tx_done <= 1'b0;
            tx_idx  <= '0;
            tx_len  <= '0;
        end else begin
            tx_done <= 1'b0;
            if (!tx_busy) begin
                if (tx_req) begin
                    tx_busy <= 1'b1;
                    tx_idx  <= '0;
                    tx_len  <= tx_length;
                end
            end else if (tx_start) begin
                tx_idx <= tx_idx + 1'b1;
            end else if (tx_idx == tx_end && !tx_line_busy) begin
                // lf has left the line
                tx_busy <= 1'b0;
                tx_done <= 1'b1;
            end
        end
    end

    // snapshot of the string, taken with the request
    always_ff @(posedge sys_clk) begin
        if (!tx_busy && tx_req) begin
            tx_buf <= tx_string;
        end
    end

    uart_tx #(
        .CLK_FREQ  (CLK_FREQ),
        .BAUD_RATE (BAUD_RATE)
    ) u_uart_tx (
        .sys_clk   (sys_clk),
        .sys_rst_n (sys_rst_n),
        .tx_start  (tx_start),
        .tx_byte   (tx_char),
        .txd       (uart_tx_port),
        .tx_busy   (tx_line_busy)
    );

endmodule

// ==== logic/uart_echo.sv ====
// uart echo top level
// every received string is sent straight back with cr lf,
// and the last received byte is shown on uart_rx_data
`timescale 1ns/1ps

module uart_echo #(
    parameter int CLK_FREQ  = 50_000_000,
    parameter int BAUD_RATE = 115_200,
    parameter int MAX_LEN   = 32
) (
    input  logic                      sys_clk,
    input  logic                      sys_rst_n,
    input  logic                      uart_rx_port,
    output logic                      uart_tx_port,
    output uart_echo_pkg::uart_byte_t uart_rx_data
);
    import uart_echo_pkg::*;

    // receive string goes straight back to the transmit side
    uart_byte_t [MAX_LEN-1:0] string_rx;
    len_t                     string_rx_length;
    logic                     string_rx_done;

    len_t                     string_tx_length;
    logic                     string_tx_req;

    uart_byte_t               rx_byte;
    logic                     rx_byte_valid;

    // one register stage from a closed string to the echo request
    always_ff @(posedge sys_clk) begin
        if (!sys_rst_n) begin
            string_tx_req    <= 1'b0;
            string_tx_length <= '0;
        end else begin
            string_tx_req <= string_rx_done;
            if (string_rx_done) begin
                string_tx_length <= string_rx_length;
            end
        end
    end

    // last good byte from the receiver
    always_ff @(posedge sys_clk) begin
        if (!sys_rst_n) begin
            uart_rx_data <= '0;
        end else if (rx_byte_valid) begin
            uart_rx_data <= rx_byte;
        end
    end

    uart_string_handle #(
        .CLK_FREQ  (CLK_FREQ),
        .BAUD_RATE (BAUD_RATE),
        .MAX_LEN   (MAX_LEN)
    ) u_uart_string_handle (
        .sys_clk       (sys_clk),
        .sys_rst_n     (sys_rst_n),

        .tx_string     (string_rx),
        .tx_length     (string_tx_length),
        .tx_req        (string_tx_req),
        // echo status is not needed at this level
        .tx_busy       (),
        .tx_done       (),

        .rx_string     (string_rx),
        .rx_length     (string_rx_length),
        .rx_busy       (),
        .rx_done       (string_rx_done),
        .rx_byte       (rx_byte),
        .rx_byte_valid (rx_byte_valid),

        .uart_rx_port  (uart_rx_port),
        .uart_tx_port  (uart_tx_port)
    );

endmodule

// ==== tests/tb_uart_echo.sv ====
// uart echo testbench
// drives random strings onto the serial input, decodes the echo on the output
// and compares it with a model built from the bytes that were sent
`timescale 1ns/1ps

module tb_uart_echo;
    import uart_echo_pkg::*;

    localparam int CLK_FREQ  = 1_250_000;
    localparam int BAUD_RATE = 125_000;
    localparam int MAX_LEN   = 32;
    localparam int CPB       = clks_per_bit(CLK_FREQ, BAUD_RATE);
    localparam int FRAME     = 10 * CPB;
    // the output line must stay high this long before an echo counts as over
    localparam int QUIET     = 40 * CPB;
    localparam int N_RAND    = 20;
    // worst case byte count: single byte, random strings, overflow, bad stop
    localparam int MAX_BYTES = 3 + N_RAND * 33 + (MAX_LEN + 5) + 8;
    localparam int LIMIT     = MAX_BYTES * 2 * FRAME
                             + (N_RAND + 3) * (IDLE_BITS * CPB + QUIET) + 58 + 2000;

    logic        sys_clk;
    logic        sys_rst_n;
    logic        uart_rx_port;
    logic        uart_tx_port;
    uart_byte_t  uart_rx_data;

    logic [31:0] lcg_state = 32'he81b_cf9a;
    // bytes decoded from the output line, and good bytes put on the input
    uart_byte_t  echo_q[$];
    uart_byte_t  sent_q[$];
    int          starts_seen;
    string       test_name;
    int          test_errors;
    int          errors;
    int          checks;
    int          tests_run;
    int          tests_failed;

    uart_echo #(
        .CLK_FREQ  (CLK_FREQ),
        .BAUD_RATE (BAUD_RATE),
        .MAX_LEN   (MAX_LEN)
    ) DUT (
        .sys_clk      (sys_clk),
        .sys_rst_n    (sys_rst_n),
        .uart_rx_port (uart_rx_port),
        .uart_tx_port (uart_tx_port),
        .uart_rx_data (uart_rx_data)
    );

    initial begin
        sys_clk = 1'b0;
        forever #4 sys_clk = ~sys_clk;
    end

    function automatic logic [31:0] next_random();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    function automatic uart_byte_t random_byte();
        logic [31:0] r;
        r = next_random();
        return r[23:16];
    endfunction

    task automatic check_byte(input string what, input uart_byte_t expected,
                              input uart_byte_t actual);
        checks++;
        if (actual !== expected) begin
            $display("FAIL %s %s: expected %h, actual %h", test_name, what, expected, actual);
            test_errors++;
        end
    endtask

    task automatic check_len(input string what, input len_t expected, input len_t actual);
        checks++;
        if (actual !== expected) begin
            $display("FAIL %s %s: expected %0d, actual %0d", test_name, what, expected, actual);
            test_errors++;
        end
    endtask

    task automatic report_error(input string msg);
        $display("error in %s: %s", test_name, msg);
        test_errors++;
    endtask

    task automatic begin_test(input string name);
        test_name   = name;
        test_errors = 0;
        echo_q.delete();
        sent_q.delete();
    endtask

    task automatic end_test();
        tests_run++;
        errors = errors + test_errors;
        if (test_errors != 0) begin
            tests_failed++;
            $display("test %s: %0d errors", test_name, test_errors);
        end else begin
            $display("test %s: ok", test_name);
        end
    endtask

    // one 8N1 frame, lsb first
    task automatic send_byte(input uart_byte_t b, input logic bad_stop);
        logic [8:0] bits;
        bits = {b, 1'b0};
        for (int i = 0; i < 9; i++) begin
            @(posedge sys_clk);
            uart_rx_port <= bits[i];
            repeat (CPB - 1) @(posedge sys_clk);
        end
        // a bad stop bit is low through its centre, then the line goes high
        // briefly so the next start bit still has a falling edge
        @(posedge sys_clk);
        uart_rx_port <= !bad_stop;
        repeat (CPB - 2) @(posedge sys_clk);
        uart_rx_port <= 1'b1;
        @(posedge sys_clk);
        if (!bad_stop) begin
            sent_q.push_back(b);
        end
    endtask

    // echo is over once the output line has been high for QUIET cycles
    task automatic wait_quiet();
        int quiet;
        quiet = 0;
        while (quiet < QUIET) begin
            @(negedge sys_clk);
            quiet = (uart_tx_port === 1'b1) ? quiet + 1 : 0;
        end
    endtask

    // expected echo: up to MAX_LEN good bytes, later ones land during the echo
    task automatic compare_echo();
        uart_byte_t expected[$];
        int n;
        n = (sent_q.size() < MAX_LEN) ? sent_q.size() : MAX_LEN;
        for (int i = 0; i < n; i++) begin
            expected.push_back(sent_q[i]);
        end
        expected.push_back(CHAR_CR);
        expected.push_back(CHAR_LF);
        wait_quiet();
        check_len("echo length", len_t'(expected.size()), len_t'(echo_q.size()));
        for (int i = 0; i < expected.size() && i < echo_q.size(); i++) begin
            check_byte($sformatf("echo byte %0d", i), expected[i], echo_q[i]);
        end
    endtask

    // output monitor, samples each bit near its centre on the falling clock
    initial begin
        uart_byte_t b;
        starts_seen = 0;
        forever begin
            @(negedge sys_clk);
            if (uart_tx_port === 1'b0) begin
                starts_seen++;
                repeat (CPB / 2) @(negedge sys_clk);
                for (int i = 0; i < 8; i++) begin
                    repeat (CPB) @(negedge sys_clk);
                    b[i] = uart_tx_port;
                end
                repeat (CPB) @(negedge sys_clk);
                if (uart_tx_port !== 1'b1) begin
                    report_error("echo frame ended with a low stop bit");
                end
                echo_q.push_back(b);
            end
        end
    end

    initial begin
        int cycles;
        cycles = 0;
        while (cycles < LIMIT) begin
            @(posedge sys_clk);
            cycles++;
        end
        $display("timeout: the run did not finish within %0d cycles", LIMIT);
        $display("STATUS: FAIL");
        $finish;
    end

    initial begin
        uart_byte_t seen;
        uart_byte_t last_good;
        int         low_cycles;
        int         len;
        int         starts_before;
        logic [31:0] r;
        errors       = 0;
        checks       = 0;
        tests_run    = 0;
        tests_failed = 0;
        sys_rst_n    = 1'b0;
        uart_rx_port = 1'b1;
        repeat (8) @(posedge sys_clk);
        sys_rst_n <= 1'b1;

        // outputs stay quiet after reset
        begin_test("reset_idle");
        seen       = '0;
        low_cycles = 0;
        repeat (50) begin
            @(negedge sys_clk);
            seen = seen | uart_rx_data;
            if (uart_tx_port !== 1'b1) begin
                low_cycles++;
            end
        end
        check_byte("uart_rx_data", '0, seen);
        if (low_cycles != 0) begin
            report_error($sformatf("tx line was not high for %0d cycles", low_cycles));
        end
        end_test();

        begin_test("single_byte");
        send_byte(random_byte(), 1'b0);
        @(negedge sys_clk);
        check_byte("uart_rx_data", sent_q[0], uart_rx_data);
        compare_echo();
        end_test();

        for (int t = 0; t < N_RAND; t++) begin
            begin_test($sformatf("random_string_%0d", t));
            r   = next_random();
            len = 1 + int'(r[30:16]) % 31;
            for (int i = 0; i < len; i++) begin
                send_byte(random_byte(), 1'b0);
            end
            compare_echo();
            end_test();
        end

        // full buffer closes the string without any idle gap
        begin_test("overflow");
        starts_before = starts_seen;
        for (int i = 0; i < MAX_LEN + 3; i++) begin
            send_byte(random_byte(), 1'b0);
            if (i == MAX_LEN && starts_seen == starts_before) begin
                report_error("echo had not started after the buffer filled");
            end
        end
        compare_echo();
        end_test();

        begin_test("bad_stop");
        for (int i = 0; i < 3; i++) begin
            send_byte(random_byte(), 1'b0);
        end
        last_good = sent_q[$];
        // the dropped byte differs from the last good one in every bit
        send_byte(~last_good, 1'b1);
        @(negedge sys_clk);
        check_byte("uart_rx_data after framing error", last_good, uart_rx_data);
        for (int i = 0; i < 2; i++) begin
            send_byte(random_byte(), 1'b0);
        end
        compare_echo();
        end_test();

        $display("tests: %0d run, %0d failed; checks: %0d, errors: %0d",
                 tests_run, tests_failed, checks, errors);
        if (errors == 0) begin
            $display("STATUS: PASS");
        end else begin
            $display("STATUS: FAIL");
        end
        $finish;
    end

endmodule

// ==== uart_echo.f ====
logic/uart_echo_pkg.sv
logic/uart_rx.sv
logic/uart_tx.sv
logic/uart_string_handle.sv
logic/uart_echo.sv
tests/tb_uart_echo.sv

// ==== run_sim.sh ====
#!/bin/sh
# build and run the uart echo testbench with verilator
# the verdict comes from the simulation log

cd "$(dirname "$0")" || exit 1

LOG=sim.log
OBJ=obj_dir

verilator --binary --timing -Wno-fatal --top-module tb_uart_echo \
    -f uart_echo.f -Mdir "$OBJ" -o sim_uart_echo
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

"$OBJ/sim_uart_echo" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "STATUS: FAIL" "$LOG"; then
    exit 1
fi
if ! grep -q "STATUS: PASS" "$LOG"; then
    echo "no verdict found in $LOG"
    exit 1
fi
exit 0
